// ==== cpuFrontTop.f ====
+incdir+design
+incdir+dv
design/cpuFrontPkg.sv
design/memPortIf.sv
design/memArbiter.sv
design/instrMem.sv
design/instructionFetch.sv
design/instructionDecoder.sv
design/cpuFrontTop.sv
dv/cpuFrontTb.sv

// ==== design/cpuFrontPkg.sv ====
`default_nettype none

`include "cpuFront_cfg.svh"

package cpuFrontPkg;

    typedef struct packed {
        logic [`ID_WIDTH-1:0]     id;
        logic [`REG_WIDTH-1:0]    regD;
        logic [`REG_WIDTH-1:0]    regA;
        logic [`REG_WIDTH-1:0]    regB;
        logic [`OFFSET_WIDTH-1:0] offset;
        logic [`COND_WIDTH-1:0]   branchCond;
    } decodedInstr;

    // SWI and interrupt slots
    localparam logic [`ID_WIDTH-1:0] idSysCall   = 7'h48;
    // Word FFFF
    localparam logic [`ID_WIDTH-1:0] idReset     = 7'h64;
    localparam logic [`ID_WIDTH-1:0] idUndefined = 7'h7f;

endpackage

`default_nettype wire

// ==== design/cpuFrontTop.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuFront_cfg.svh"

module cpuFrontTop (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     run,
    input  logic                     loadWe,
    input  logic [`ADDR_WIDTH-1:0]   loadAddr,
    input  logic [`INSTR_WIDTH-1:0]  loadData,
    input  logic                     irqUser,
    input  logic                     irqWatchdog,
    output logic [`ID_WIDTH-1:0]     decId,
    output logic [`REG_WIDTH-1:0]    decRegD,
    output logic [`REG_WIDTH-1:0]    decRegA,
    output logic [`REG_WIDTH-1:0]    decRegB,
    output logic [`OFFSET_WIDTH-1:0] decOffset,
    output logic [`COND_WIDTH-1:0]   decBranchCond,
    output logic                     decodeValid,
    output logic [`ADDR_WIDTH-1:0]   decodePc
);

    import cpuFrontPkg::*;

    logic [`INSTR_WIDTH-1:0] instr;
    logic                    instrValid;
    logic [`ADDR_WIDTH-1:0]  instrPc;
    logic                    userReq;
    logic                    wdIrq;
    decodedInstr             decoded;

    memPortIf loadPort ();
    memPortIf fetchPort ();
    memPortIf memPort ();

    // Loader pins, write-only
    assign loadPort.req   = loadWe;
    assign loadPort.we    = loadWe;
    assign loadPort.addr  = loadAddr;
    assign loadPort.wdata = loadData;

    memArbiter uArbiter (
        .loadPort  (loadPort.arbiter),
        .fetchPort (fetchPort.arbiter),
        .memPort   (memPort.requester)
    );

    instrMem uMem (.clk(clk), .memPort(memPort.memory));

    instructionFetch uFetch (
        .clk(clk), .rstN(rstN), .run(run),
        .irqUser(irqUser), .irqWatchdog(irqWatchdog),
        .fetchPort(fetchPort.requester),
        .instr(instr), .instrValid(instrValid), .instrPc(instrPc),
        .userReq(userReq), .wdIrq(wdIrq)
    );

    instructionDecoder uDecoder (
        .clk(clk), .rstN(rstN),
        .instr(instr), .instrValid(instrValid), .instrPc(instrPc),
        .userReq(userReq), .wdIrq(wdIrq),
        .decoded(decoded), .decodeValid(decodeValid), .decodePc(decodePc)
    );

    assign decId         = decoded.id;
    assign decRegD       = decoded.regD;
    assign decRegA       = decoded.regA;
    assign decRegB       = decoded.regB;
    assign decOffset     = decoded.offset;
    assign decBranchCond = decoded.branchCond;

endmodule

`default_nettype wire

// ==== design/cpuFront_cfg.svh ====
`ifndef CPU_FRONT_CFG_SVH
`define CPU_FRONT_CFG_SVH

// Instruction word and decoded field widths
`define INSTR_WIDTH  16
`define ID_WIDTH     7
`define REG_WIDTH    4
`define OFFSET_WIDTH 12

// All ones means no condition
`define COND_WIDTH   5

// Instruction memory
`define MEM_DEPTH    256
`define ADDR_WIDTH   8

// OS entry point for the later stages
`define OS_START     2048

`endif

// ==== design/instrMem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuFront_cfg.svh"

module instrMem (
    input  logic       clk,
    memPortIf.memory   memPort
);

    logic [`INSTR_WIDTH-1:0] mem [`MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (memPort.req) begin
            if (memPort.we) begin
                mem[memPort.addr] <= memPort.wdata;
            end else begin
                memPort.rdata <= mem[memPort.addr]; // One-cycle read latency
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/instructionDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuFront_cfg.svh"

module instructionDecoder (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [`INSTR_WIDTH-1:0]  instr,
    input  logic                     instrValid,
    input  logic [`ADDR_WIDTH-1:0]   instrPc,
    input  logic                     userReq,
    input  logic                     wdIrq,
    output cpuFrontPkg::decodedInstr decoded,
    output logic                     decodeValid,
    output logic [`ADDR_WIDTH-1:0]   decodePc
);

    import cpuFrontPkg::*;

    decodedInstr            nextDec;
    logic [3:0]             opcode;
    logic                   op;
    logic [3:0]             funct2;
    logic [1:0]             funct1;
    logic [`REG_WIDTH-1:0]  rLo;   // Bits 2:0
    logic [`REG_WIDTH-1:0]  rMid;  // Bits 5:3
    logic [`REG_WIDTH-1:0]  rHi;   // Bits 8:6
    logic [`REG_WIDTH-1:0]  rTop;  // Bits 10:8

    assign opcode = instr[15:12];
    assign op     = instr[11];
    assign funct2 = instr[11:8];
    assign funct1 = instr[7:6];
    assign rLo    = {1'b0, instr[2:0]};
    assign rMid   = {1'b0, instr[5:3]};
    assign rHi    = {1'b0, instr[8:6]};
    assign rTop   = {1'b0, instr[10:8]};

    always_comb begin
        nextDec            = '0;
        nextDec.branchCond = {`COND_WIDTH{1'b1}};
        if (userReq || wdIrq) begin
            nextDec.id     = idSysCall;
            nextDec.offset = userReq ? `OFFSET_WIDTH'(3) : '0;
        end else begin
            case (opcode)
                4'd0: begin
                    nextDec.id     = op ? 7'h02 : 7'h01;
                    nextDec.offset = `OFFSET_WIDTH'(instr[10:6]);
                    nextDec.regD   = rLo;
                    nextDec.regA   = rMid;
                end
                4'd1: begin
                    nextDec.regD = rLo;
                    nextDec.regA = rMid;
                    if (!op) begin
                        nextDec.id     = 7'h03;
                        nextDec.offset = `OFFSET_WIDTH'(instr[10:6]);
                    end else if (!instr[10]) begin // Register forms
                        nextDec.id   = instr[9] ? 7'h05 : 7'h04;
                        nextDec.regB = rHi;
                    end else begin                 // 3-bit immediate forms
                        nextDec.id     = instr[9] ? 7'h07 : 7'h06;
                        nextDec.offset = `OFFSET_WIDTH'(instr[8:6]);
                    end
                end
                4'd2, 4'd3: begin
                    nextDec.id     = `ID_WIDTH'(7'h08 + {opcode[0], op});
                    nextDec.offset = `OFFSET_WIDTH'(instr[7:0]);
                    nextDec.regD   = rTop;
                    nextDec.regA   = rTop;
                end
                4'd4: begin
                    if (op) begin
                        nextDec.id     = 7'h27;
                        nextDec.offset = `OFFSET_WIDTH'(instr[7:0]);
                        nextDec.regD   = rTop;
                        nextDec.regA   = 4'hf;
                        nextDec.regB   = rTop;
                    end else begin
                        nextDec.regD = rLo;
                        nextDec.regA = rLo;
                        nextDec.regB = rMid;
                        case (funct2)
                            4'd0, 4'd1, 4'd2, 4'd3: begin // ALU group, IDs 0C to 1B
                                nextDec.id = `ID_WIDTH'(7'h0c + {funct2[1:0], funct1});
                            end
                            4'd4, 4'd5, 4'd6: begin // High register forms
                                nextDec.regB[3] = funct1[0] & (funct1 != 2'd3 || funct2 != 4'd5);
                                nextDec.regD[3] = funct1[1];
                                nextDec.regA[3] = funct1[1];
                                if (funct2 == 4'd6) begin
                                    nextDec.id = `ID_WIDTH'(7'h22 + funct1);
                                end else if (funct1 == 2'd0) begin
                                    nextDec.id = 7'h0c;
                                end else begin
                                    nextDec.id = `ID_WIDTH'((funct2 == 4'd4 ? 7'h1b : 7'h1e)
                                                            + funct1);
                                end
                            end
                            4'd7: begin // BX
                                nextDec.branchCond = {1'b0, instr[7:4]};
                                nextDec.id   = (instr[7:4] == 4'hf) ? 7'h4d : 7'h26;
                                nextDec.regA = 4'hf;
                                nextDec.regB = rLo;
                            end
                            default: nextDec.id = 7'h7d;
                        endcase
                    end
                end
                4'd5: begin
                    nextDec.id   = `ID_WIDTH'(7'h28 + instr[11:9]);
                    nextDec.regD = rLo;
                    nextDec.regA = rMid;
                    nextDec.regB = rHi;
                end
                4'd6, 4'd7, 4'd8: begin // Loads and stores, IDs 30 to 35
                    nextDec.id     = `ID_WIDTH'(7'h30 + {opcode - 4'd6, op});
                    nextDec.offset = `OFFSET_WIDTH'(instr[10:6]);
                    nextDec.regD   = rLo;
                    nextDec.regA   = rMid;
                end
                4'd9, 4'd10: begin
                    nextDec.id     = `ID_WIDTH'(7'h36 + {opcode[1], op});
                    nextDec.offset = `OFFSET_WIDTH'(instr[7:0]);
                    nextDec.regD   = rTop;
                    nextDec.regA   = (opcode[1] && !op) ? 4'hf : 4'he; // PC or SP
                end
                4'd11: begin
                    case (funct2)
                        4'd0: begin
                            nextDec.id   = (funct1 == 2'd1) ? 7'h4c : 7'h3a;
                            nextDec.regD = {1'b1, instr[2:0]};
                            nextDec.regA = {1'b1, instr[2:0]};
                        end
                        4'd2, 4'd10: begin
                            nextDec.id   = `ID_WIDTH'((funct2[3] ? 7'h3f : 7'h3b) + funct1);
                            nextDec.regD = rLo;
                            nextDec.regB = rMid;
                        end
                        4'd4: begin
                            nextDec.id   = 7'h43;
                            nextDec.regD = rLo;
                        end
                        4'd13: begin
                            nextDec.id   = 7'h44;
                            nextDec.regD = rLo;
                        end
                        4'd14: begin // OUTPUT, PAUSE, INPUT
                            nextDec.id   = (funct1 == 2'd3) ? 7'h7a : `ID_WIDTH'(7'h45 + funct1);
                            nextDec.regD = funct1[0] ? '0 : rLo;
                        end
                        default: nextDec.id = 7'h7a;
                    endcase
                end
                4'd12: begin
                    nextDec.id     = idSysCall;
                    nextDec.offset = `OFFSET_WIDTH'(instr[10:6]);
                    nextDec.regB   = 4'h7; // Link register
                end
                4'd13: begin
                    nextDec.id         = 7'h49;
                    nextDec.branchCond = {1'b0, instr[11:8]};
                    nextDec.offset     = `OFFSET_WIDTH'(instr[7:0]);
                    nextDec.regA       = 4'hf;
                end
                4'd14: nextDec.id = op ? 7'h4b : 7'h4a; // HLT or NOP
                default: nextDec.id = (instr == 16'hffff) ? idReset : idUndefined;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decodeValid <= 1'b0;
        end else begin
            decodeValid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            decoded  <= nextDec;
            decodePc <= instrPc;
        end
    end

endmodule

`default_nettype wire

// ==== design/instructionFetch.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuFront_cfg.svh"

module instructionFetch (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     run,
    input  logic                     irqUser,
    input  logic                     irqWatchdog,
    memPortIf.requester              fetchPort,
    output logic [`INSTR_WIDTH-1:0]  instr,
    output logic                     instrValid,
    output logic [`ADDR_WIDTH-1:0]   instrPc,
    output logic                     userReq,
    output logic                     wdIrq
);

    logic [`ADDR_WIDTH-1:0] pc;
    logic [`ADDR_WIDTH-1:0] inFlightPc;
    logic                   inFlight;
    logic                   userPend;
    logic                   wdPend;
    logic                   irqSlot;
    logic                   readFire;

    assign fetchPort.req   = run & ~(userPend | wdPend); // Hold off while an IRQ waits
    assign fetchPort.we    = 1'b0;
    assign fetchPort.addr  = pc;
    assign fetchPort.wdata = '0;

    assign readFire = fetchPort.req & fetchPort.gnt;
    assign irqSlot  = (userPend | wdPend) & ~inFlight; // Drained, take the slot

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc       <= '0;
            inFlight <= 1'b0;
            userPend <= 1'b0;
            wdPend   <= 1'b0;
        end else begin
            inFlight <= readFire;
            if (readFire) begin
                pc <= (pc == `ADDR_WIDTH'(`MEM_DEPTH - 1)) ? '0 : pc + 1'b1;
            end
            // A pulse landing on the slot cycle gets a slot of its own
            userPend <= (userPend & ~irqSlot) | irqUser;
            wdPend   <= (wdPend & ~irqSlot) | irqWatchdog;
        end
    end

    always_ff @(posedge clk) begin
        if (readFire) begin
            inFlightPc <= pc;
        end
    end

    assign instr      = fetchPort.rdata;
    assign instrValid = inFlight | irqSlot;
    assign instrPc    = irqSlot ? pc : inFlightPc;
    assign userReq    = irqSlot & userPend;
    assign wdIrq      = irqSlot & wdPend;

endmodule

`default_nettype wire

// ==== design/memArbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuFront_cfg.svh"

module memArbiter (
    memPortIf.arbiter   loadPort,
    memPortIf.arbiter   fetchPort,
    memPortIf.requester memPort
);

    logic loadSel;

    assign loadSel = loadPort.req; // Loader always wins

    assign memPort.req   = loadSel | fetchPort.req;
    assign memPort.we    = loadSel ? loadPort.we    : fetchPort.we;
    assign memPort.addr  = loadSel ? loadPort.addr  : fetchPort.addr;
    assign memPort.wdata = loadSel ? loadPort.wdata : fetchPort.wdata;

    assign loadPort.gnt  = loadSel;
    assign fetchPort.gnt = fetchPort.req & ~loadSel; // Stalled by loader writes

    // Read data fans out, only the requester with a read in flight uses it
    assign loadPort.rdata  = memPort.rdata;
    assign fetchPort.rdata = memPort.rdata;

endmodule

`default_nettype wire

// ==== design/memPortIf.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuFront_cfg.svh"

interface memPortIf;

    logic                     req;
    logic                     we;
    logic [`ADDR_WIDTH-1:0]   addr;
    logic [`INSTR_WIDTH-1:0]  wdata;
    logic                     gnt;   // Accepted this cycle
    logic [`INSTR_WIDTH-1:0]  rdata; // Valid the cycle after a granted read

    modport requester (output req, we, addr, wdata, input gnt, rdata);
    modport arbiter   (input req, we, addr, wdata, output gnt, rdata);
    modport memory    (input req, we, addr, wdata, output rdata);

endinterface

`default_nettype wire

// ==== dv/cpuFrontModel.svh ====
`ifndef CPU_FRONT_MODEL_SVH
`define CPU_FRONT_MODEL_SVH

logic [15:0] lfsrState = 16'd58583;

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// One LFSR step per bit taken, n up to 16
function automatic logic [15:0] randWord(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsrState = lfsrNext(lfsrState);
        r = {r[14:0], lfsrState[0]};
    end
    return r;
endfunction

function automatic decodedInstr modelDecode(input logic [15:0] w, input logic isUser,
                                            input logic isWd);
    decodedInstr d;
    logic [3:0]  opc;
    logic [3:0]  f2;
    logic [1:0]  f1;
    logic [3:0]  lo;
    logic [3:0]  mid;
    logic [3:0]  top;
    opc = w[15:12];
    f2  = w[11:8];
    f1  = w[7:6];
    lo  = {1'b0, w[2:0]};
    mid = {1'b0, w[5:3]};
    top = {1'b0, w[10:8]};
    d = '0;
    d.branchCond = 5'h1f;
    if (isUser || isWd) begin
        d.id     = 7'h48;
        d.offset = isUser ? 12'd3 : 12'd0;
        return d;
    end
    case (opc)
        4'd0, 4'd6, 4'd7, 4'd8: begin // 5-bit immediate layout
            d.id = (opc == 4'd0) ? 7'h01 + 7'(w[11])
                                 : 7'h30 + 7'(2 * (opc - 4'd6)) + 7'(w[11]);
            d.offset = 12'(w[10:6]);
            d.regD   = lo;
            d.regA   = mid;
        end
        4'd1: begin
            d.regD = lo;
            d.regA = mid;
            if (!w[11]) begin
                d.id     = 7'h03;
                d.offset = 12'(w[10:6]);
            end else if (!w[10]) begin
                d.id   = 7'h04 + 7'(w[9]);
                d.regB = {1'b0, w[8:6]};
            end else begin
                d.id     = 7'h06 + 7'(w[9]);
                d.offset = 12'(w[8:6]);
            end
        end
        4'd2, 4'd3: begin
            d.id     = 7'h08 + 7'(2 * (opc - 4'd2)) + 7'(w[11]);
            d.offset = 12'(w[7:0]);
            d.regD   = top;
            d.regA   = top;
        end
        4'd4: begin
            if (w[11]) begin
                d.id     = 7'h27;
                d.offset = 12'(w[7:0]);
                d.regD   = top;
                d.regA   = 4'hf;
                d.regB   = top;
            end else if (f2 <= 4'd3) begin
                d.id   = 7'h0c + 7'({f2[1:0], f1});
                d.regD = lo;
                d.regA = lo;
                d.regB = mid;
            end else if (f2 <= 4'd6) begin // High registers
                d.regD = {f1[1], w[2:0]};
                d.regA = {f1[1], w[2:0]};
                d.regB = {f1[0] && !(f1 == 2'd3 && f2 == 4'd5), w[5:3]};
                if (f2 == 4'd6) d.id = 7'h22 + 7'(f1);
                else if (f1 == 2'd0) d.id = 7'h0c;
                else if (f2 == 4'd4) d.id = 7'h1b + 7'(f1);
                else d.id = 7'h1e + 7'(f1);
            end else begin
                d.id         = (w[7:4] == 4'hf) ? 7'h4d : 7'h26;
                d.branchCond = {1'b0, w[7:4]};
                d.regD       = lo;
                d.regA       = 4'hf;
                d.regB       = lo;
            end
        end
        4'd5: begin
            d.id   = 7'h28 + 7'(w[11:9]);
            d.regD = lo;
            d.regA = mid;
            d.regB = {1'b0, w[8:6]};
        end
        4'd9, 4'd10: begin
            d.id     = 7'h36 + 7'(2 * (opc - 4'd9)) + 7'(w[11]);
            d.offset = 12'(w[7:0]);
            d.regD   = top;
            d.regA   = (opc == 4'd10 && !w[11]) ? 4'hf : 4'he;
        end
        4'd11: begin
            d.id = 7'h7a;
            if (f2 == 4'd0) begin
                d.id   = (f1 == 2'd1) ? 7'h4c : 7'h3a;
                d.regD = {1'b1, w[2:0]};
                d.regA = {1'b1, w[2:0]};
            end else if (f2 == 4'd2 || f2 == 4'd10) begin
                d.id   = ((f2 == 4'd10) ? 7'h3f : 7'h3b) + 7'(f1);
                d.regD = lo;
                d.regB = mid;
            end else if (f2 == 4'd4 || f2 == 4'd13) begin
                d.id   = (f2 == 4'd4) ? 7'h43 : 7'h44;
                d.regD = lo;
            end else if (f2 == 4'd14) begin
                d.id   = (f1 == 2'd3) ? 7'h7a : 7'h45 + 7'(f1);
                d.regD = f1[0] ? 4'h0 : lo;
            end
        end
        4'd12: begin
            d.id     = 7'h48;
            d.offset = 12'(w[10:6]);
            d.regB   = 4'h7;
        end
        4'd13: begin
            d.id         = 7'h49;
            d.branchCond = {1'b0, w[11:8]};
            d.offset     = 12'(w[7:0]);
            d.regA       = 4'hf;
        end
        4'd14: d.id = w[11] ? 7'h4b : 7'h4a;
        default: d.id = (w == 16'hffff) ? 7'h64 : 7'h7f;
    endcase
    return d;
endfunction

`endif

// ==== dv/cpuFrontTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuFront_cfg.svh"

module cpuFrontTb;

    import cpuFrontPkg::*;

    localparam int numDecodes = 600;
    localparam int planCycles = 5 + `MEM_DEPTH + 2 * numDecodes + 20;
    localparam int cycleLimit = 4 * planCycles;

    logic                     clk;
    logic                     rstN;
    logic                     run;
    logic                     loadWe;
    logic [`ADDR_WIDTH-1:0]   loadAddr;
    logic [`INSTR_WIDTH-1:0]  loadData;
    logic                     irqUser;
    logic                     irqWatchdog;
    logic [`ID_WIDTH-1:0]     decId;
    logic [`REG_WIDTH-1:0]    decRegD;
    logic [`REG_WIDTH-1:0]    decRegA;
    logic [`REG_WIDTH-1:0]    decRegB;
    logic [`OFFSET_WIDTH-1:0] decOffset;
    logic [`COND_WIDTH-1:0]   decBranchCond;
    logic                     decodeValid;
    logic [`ADDR_WIDTH-1:0]   decodePc;

    logic [`INSTR_WIDTH-1:0] progImg [`MEM_DEPTH]; // Expected memory contents
    logic [`ADDR_WIDTH-1:0]  expPc = '0;
    logic                    loading = 1'b1;
    logic                    slotExpected = 1'b0;
    logic                    slotUser = 1'b0;
    logic                    wrapSeen = 1'b0;
    int                      errCount = 0;
    int                      checkCount = 0;
    int                      decodeCount = 0;
    int                      slotCount = 0;
    int                      slotGroups = 0;
    int                      cycleCount = 0;

    `include "cpuFrontModel.svh"

    cpuFrontTop DUT (
        .clk(clk), .rstN(rstN), .run(run),
        .loadWe(loadWe), .loadAddr(loadAddr), .loadData(loadData),
        .irqUser(irqUser), .irqWatchdog(irqWatchdog),
        .decId(decId), .decRegD(decRegD), .decRegA(decRegA), .decRegB(decRegB),
        .decOffset(decOffset), .decBranchCond(decBranchCond),
        .decodeValid(decodeValid), .decodePc(decodePc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkField(input string name, input logic [15:0] got, input logic [15:0] exp);
        checkCount++;
        assert (got == exp) else begin
            errCount++;
            $display("FAIL %s expected %h got %h at pc %h", name, exp, got, expPc);
        end
    endtask

    task automatic expectTrue(input logic cond, input string what);
        checkCount++;
        assert (cond) else begin
            errCount++;
            $display("ERROR %s", what);
        end
    endtask

    task automatic printSummary();
        $display("checks %0d errors %0d decodes %0d slots %0d cycles %0d",
                 checkCount, errCount, decodeCount, slotCount, cycleCount);
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("ERROR run timed out after %0d cycles", cycleCount);
            printSummary();
            $display("** FAIL **");
            $finish;
        end
    end

    // Outputs are registered, so sample them away from the rising edge
    always @(negedge clk) begin : checkOutputs
        decodedInstr expDec;
        logic        isSlot;
        if (rstN) begin
            if (loading) begin
                expectTrue(!decodeValid, "decodeValid went high while run was low");
            end
            if (decodeValid) begin
                isSlot = (decId == idSysCall) && (decRegB == 4'h0); // SWI always has regB 7
                if (isSlot) begin
                    expectTrue(slotExpected, "interrupt slot appeared with nothing pending");
                    expDec = modelDecode(16'h0000, slotUser, !slotUser);
                    slotExpected = 1'b0;
                    slotCount++;
                end else begin
                    expDec = modelDecode(progImg[expPc], 1'b0, 1'b0);
                    decodeCount++;
                end
                checkField("decodePc", 16'(decodePc), 16'(expPc));
                checkField("decId", 16'(decId), 16'(expDec.id));
                checkField("decRegD", 16'(decRegD), 16'(expDec.regD));
                checkField("decRegA", 16'(decRegA), 16'(expDec.regA));
                checkField("decRegB", 16'(decRegB), 16'(expDec.regB));
                checkField("decOffset", 16'(decOffset), 16'(expDec.offset));
                checkField("decBranchCond", 16'(decBranchCond), 16'(expDec.branchCond));
                if (!isSlot) begin
                    if (decodePc == '0 && decodeCount > 1) wrapSeen = 1'b1;
                    expPc = expPc + 8'd1; // Wraps with the memory depth
                end
            end
        end
    end

    initial begin : stimulus
        logic [15:0]            word;
        logic [15:0]            kind;
        logic [`ADDR_WIDTH-1:0] wrAddr;
        rstN        <= 1'b0;
        run         <= 1'b0;
        loadWe      <= 1'b0;
        loadAddr    <= '0;
        loadData    <= '0;
        irqUser     <= 1'b0;
        irqWatchdog <= 1'b0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        for (int addr = 0; addr < `MEM_DEPTH; addr++) begin
            @(posedge clk);
            word = randWord(16);
            case (addr)
                5, 250:  word = 16'hffff; // Reset word
                9:       word = 16'h47f3; // BX, condition F
                254:     word = 16'h47f0;
                17:      word = 16'hb123; // Opcode 11 holes
                42:      word = 16'hbec5;
                default: ;
            endcase
            loadWe   <= 1'b1;
            loadAddr <= 8'(addr);
            loadData <= word;
            progImg[addr] = word;
        end
        @(posedge clk);
        loadWe <= 1'b0;
        repeat (4) @(posedge clk);
        loading = 1'b0;
        run <= 1'b1;

        while (decodeCount < numDecodes) begin
            @(posedge clk);
            loadWe      <= 1'b0;
            irqUser     <= 1'b0;
            irqWatchdog <= 1'b0;
            if (!slotExpected && randWord(4) == 16'd0) begin
                kind = randWord(2); // 0 user, 1 watchdog, 2 and 3 both
                irqUser     <= (kind != 16'd1);
                irqWatchdog <= (kind != 16'd0);
                slotUser     = (kind != 16'd1);
                slotExpected = 1'b1;
                slotGroups++;
            end
            if (randWord(3) == 16'd0) begin
                wrAddr = expPc + 8'd128; // Half the memory away from the fetch pc
                word   = randWord(16);
                loadWe   <= 1'b1;
                loadAddr <= wrAddr;
                loadData <= word;
                progImg[wrAddr] = word;
            end
        end
        @(posedge clk);
        loadWe      <= 1'b0;
        irqUser     <= 1'b0;
        irqWatchdog <= 1'b0;
        while (slotExpected) @(posedge clk);
        repeat (4) @(posedge clk);

        expectTrue(wrapSeen, "decodePc never wrapped past the last address");
        expectTrue(slotCount == slotGroups, "interrupt slot count differs from the pulse groups");
        printSummary();
        if (errCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module cpuFrontTb -f cpuFrontTop.f -o cpuFrontSim

./obj_dir/cpuFrontSim > sim.log 2>&1 || true
cat sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    exit 0
fi
exit 1
